//--- design/itlb_pkg.sv
// types and constants shared by the instruction-side translation path
// 4 KB pages only, one page per TLB entry, no page mask
// segment windows follow the MIPS kseg0/kseg1 layout on the top nibble
package itlb_pkg;

    // page geometry
    localparam int PAGE_OFFS_W = 12;
    localparam int VPN_W       = 32 - PAGE_OFFS_W;
    localparam int ASID_W      = 4;
    localparam int CATTR_W     = 3;

    // address and field types
    typedef logic [31:0]            vaddr_t;
    typedef logic [31:0]            paddr_t;
    typedef logic [VPN_W-1:0]       vpn_t;
    typedef logic [VPN_W-1:0]       pfn_t;
    typedef logic [ASID_W-1:0]      asid_t;
    typedef logic [CATTR_W-1:0]     cattr_t;
    typedef logic [PAGE_OFFS_W-1:0] offs_t;

    // kseg0 is cached, kseg1 uncached
    localparam cattr_t KSEG0_CATTR = 3'd3;
    localparam cattr_t KSEG1_CATTR = 3'd2;

    // address kind, from vaddr[31:28]
    typedef enum logic [1:0]
    {
        SEG_MAPPED,
        SEG_KSEG0,
        SEG_KSEG1
    } seg_e;

    // virtual page number of a fetch address
    function automatic vpn_t vpn_of(input vaddr_t va);
        return va[31:PAGE_OFFS_W];
    endfunction

    // byte offset inside the page
    function automatic offs_t offs_of(input vaddr_t va);
        return va[PAGE_OFFS_W-1:0];
    endfunction

    // 8..9 kseg0, A..B kseg1, the rest goes through the TLB
    function automatic seg_e seg_of(input vaddr_t va);
        seg_e seg;
        case (va[31:28])
            4'h8, 4'h9:
                seg = SEG_KSEG0;
            4'hA, 4'hB:
                seg = SEG_KSEG1;
            default:
                seg = SEG_MAPPED;
        endcase
        return seg;
    endfunction

endpackage

//--- design/fetch_issue.sv
`timescale 1ns/1ps
// issue stage, one request per cycle while credits remain
// CREDITS must match the downstream buffer depth
// downstream never returns more credits than it was given
module fetch_issue
    import itlb_pkg::*;
#(
    parameter int CREDITS = 4
)
(
    input  logic   clk,
    input  logic   rst_n,
    // fetch request
    input  logic   req_valid,
    input  vaddr_t req_vaddr,
    input  asid_t  req_asid,
    output logic   req_ready,
    // one pulse per freed downstream slot
    input  logic   credit_return,
    // stage 0
    output logic   s0_valid,
    output vaddr_t s0_vaddr,
    output asid_t  s0_asid
);

    localparam int CNT_W = $clog2(CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;
    logic             accept;

    // ready while at least one slot is free downstream
    assign req_ready = (credit_cnt != '0);
    assign accept    = req_valid && req_ready;

    // credit counter
    // accept and return in the same cycle cancel out
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            credit_cnt <= CNT_W'(CREDITS);
        end
        else if (accept && !credit_return)
        begin
            credit_cnt <= credit_cnt - 1'b1;
        end
        else if (credit_return && !accept)
        begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    // stage 0 valid, low on idle cycles
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s0_valid <= 1'b0;
        end
        else
        begin
            s0_valid <= accept;
        end
    end

    // stage 0 payload, only loaded on accept
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            s0_vaddr <= req_vaddr;
            s0_asid  <= req_asid;
        end
    end

endmodule

//--- design/tlb_lookup.sv
`timescale 1ns/1ps
// fully associative TLB, one 4 KB page per entry, lowest index wins
// writes must not overlap a lookup of the same entry
// lookup runs for every address, segment decode is done downstream
module tlb_lookup
    import itlb_pkg::*;
#(
    parameter int TLB_ENTRIES = 16
)
(
    input  logic                           clk,
    input  logic                           rst_n,
    // stage 0
    input  logic                           s0_valid,
    input  vaddr_t                         s0_vaddr,
    input  asid_t                          s0_asid,
    // write port
    input  logic                           tlb_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_windex,
    input  vpn_t                           tlb_wvpn,
    input  asid_t                          tlb_wasid,
    input  logic                           tlb_wg,
    input  pfn_t                           tlb_wpfn,
    input  cattr_t                         tlb_wc,
    input  logic                           tlb_wv,
    // stage 1
    output logic                           s1_valid,
    output vaddr_t                         s1_vaddr,
    output logic                           s1_found,
    output pfn_t                           s1_pfn,
    output cattr_t                         s1_c,
    output logic                           s1_v
);

    localparam int IDX_W = $clog2(TLB_ENTRIES);

    // entry array
    vpn_t   ent_vpn  [TLB_ENTRIES];
    asid_t  ent_asid [TLB_ENTRIES];
    logic   ent_g    [TLB_ENTRIES];
    pfn_t   ent_pfn  [TLB_ENTRIES];
    cattr_t ent_c    [TLB_ENTRIES];
    logic   ent_v    [TLB_ENTRIES];

    logic [TLB_ENTRIES-1:0] ent_hit;
    logic                   hit_found;
    logic [IDX_W-1:0]       hit_idx;

    // entry write, whole array cleared on reset
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < TLB_ENTRIES; i++)
            begin
                ent_vpn[i]  <= '0;
                ent_asid[i] <= '0;
                ent_g[i]    <= 1'b0;
                ent_pfn[i]  <= '0;
                ent_c[i]    <= '0;
                ent_v[i]    <= 1'b0;
            end
        end
        else if (tlb_we)
        begin
            ent_vpn[tlb_windex]  <= tlb_wvpn;
            ent_asid[tlb_windex] <= tlb_wasid;
            ent_g[tlb_windex]    <= tlb_wg;
            ent_pfn[tlb_windex]  <= tlb_wpfn;
            ent_c[tlb_windex]    <= tlb_wc;
            ent_v[tlb_windex]    <= tlb_wv;
        end
    end

    // parallel compare, vpn plus global or asid
    // v is not part of the match, an invalid hit still counts as found
    for (genvar i = 0; i < TLB_ENTRIES; i++)
    begin : g_match
        assign ent_hit[i] = (ent_vpn[i] == vpn_of(s0_vaddr)) &&
                            (ent_g[i] || (ent_asid[i] == s0_asid));
    end

    // priority pick, scan from the top so the lowest hit is kept
    always_comb
    begin
        hit_found = 1'b0;
        hit_idx   = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--)
        begin
            if (ent_hit[i])
            begin
                hit_found = 1'b1;
                hit_idx   = IDX_W'(i);
            end
        end
    end

    // stage 1 valid
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s1_valid <= 1'b0;
        end
        else
        begin
            s1_valid <= s0_valid;
        end
    end

    // stage 1 payload
    // fields of entry 0 ride along on a miss, found qualifies them
    always_ff @(posedge clk)
    begin
        if (s0_valid)
        begin
            s1_vaddr <= s0_vaddr;
            s1_found <= hit_found;
            s1_pfn   <= ent_pfn[hit_idx];
            s1_c     <= ent_c[hit_idx];
            s1_v     <= ent_v[hit_idx];
        end
    end

endmodule

//--- design/itlb_stage.sv
`timescale 1ns/1ps
// translation stage, segment decode and physical address forming
// refill and invalid only raised for mapped addresses, never both
// exceptions return zero address and zero attribute
module itlb_stage
    import itlb_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    // stage 1 from the lookup
    input  logic   s1_valid,
    input  vaddr_t s1_vaddr,
    input  logic   s1_found,
    input  pfn_t   s1_pfn,
    input  cattr_t s1_c,
    input  logic   s1_v,
    // response, one pulse per item
    output logic   resp_valid,
    output paddr_t resp_paddr,
    output cattr_t resp_cattr,
    output logic   resp_refill,
    output logic   resp_invalid
);

    seg_e   seg;
    paddr_t paddr_nxt;
    cattr_t cattr_nxt;
    logic   refill_nxt;
    logic   invalid_nxt;

    // address kind from the top nibble
    assign seg = seg_of(s1_vaddr);

    always_comb
    begin
        paddr_nxt   = '0;
        cattr_nxt   = '0;
        refill_nxt  = 1'b0;
        invalid_nxt = 1'b0;
        case (seg)
            SEG_KSEG0:
            begin
                // drop bit 31
                paddr_nxt = {1'b0, s1_vaddr[30:0]};
                cattr_nxt = KSEG0_CATTR;
            end
            SEG_KSEG1:
            begin
                // drop bits 31..29
                paddr_nxt = {3'b000, s1_vaddr[28:0]};
                cattr_nxt = KSEG1_CATTR;
            end
            default:
            begin
                if (!s1_found)
                begin
                    // no entry, software refill
                    refill_nxt = 1'b1;
                end
                else if (!s1_v)
                begin
                    invalid_nxt = 1'b1;
                end
                else
                begin
                    // frame plus page offset
                    paddr_nxt = {s1_pfn, offs_of(s1_vaddr)};
                    cattr_nxt = s1_c;
                end
            end
        endcase
    end

    // response valid
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            resp_valid <= 1'b0;
        end
        else
        begin
            resp_valid <= s1_valid;
        end
    end

    // response payload, held between pulses
    always_ff @(posedge clk)
    begin
        if (s1_valid)
        begin
            resp_paddr   <= paddr_nxt;
            resp_cattr   <= cattr_nxt;
            resp_refill  <= refill_nxt;
            resp_invalid <= invalid_nxt;
        end
    end

endmodule

//--- design/itlb_xlate_top.sv
`timescale 1ns/1ps
// instruction-side translation path, fixed 3 cycle latency, no stalls
// downstream must own CREDITS slots and return one credit per freed slot
// TLB writes only while the pipeline is empty
module itlb_xlate_top
    import itlb_pkg::*;
#(
    parameter int TLB_ENTRIES = 16,
    parameter int CREDITS     = 4
)
(
    input  logic                           clk,
    input  logic                           rst_n,
    // fetch request
    input  logic                           req_valid,
    input  vaddr_t                         req_vaddr,
    input  asid_t                          req_asid,
    output logic                           req_ready,
    // downstream credit
    input  logic                           credit_return,
    // TLB write port
    input  logic                           tlb_we,
    input  logic [$clog2(TLB_ENTRIES)-1:0] tlb_windex,
    input  vpn_t                           tlb_wvpn,
    input  asid_t                          tlb_wasid,
    input  logic                           tlb_wg,
    input  pfn_t                           tlb_wpfn,
    input  cattr_t                         tlb_wc,
    input  logic                           tlb_wv,
    // response
    output logic                           resp_valid,
    output paddr_t                         resp_paddr,
    output cattr_t                         resp_cattr,
    output logic                           resp_refill,
    output logic                           resp_invalid
);

    // stage 0, issue to lookup
    logic   s0_valid;
    vaddr_t s0_vaddr;
    asid_t  s0_asid;

    // stage 1, lookup to translation
    logic   s1_valid;
    vaddr_t s1_vaddr;
    logic   s1_found;
    pfn_t   s1_pfn;
    cattr_t s1_c;
    logic   s1_v;

    fetch_issue #(
        .CREDITS       (CREDITS)
    ) fetch_issue_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_vaddr     (req_vaddr),
        .req_asid      (req_asid),
        .req_ready     (req_ready),
        .credit_return (credit_return),
        .s0_valid      (s0_valid),
        .s0_vaddr      (s0_vaddr),
        .s0_asid       (s0_asid)
    );

    tlb_lookup #(
        .TLB_ENTRIES   (TLB_ENTRIES)
    ) tlb_lookup_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .s0_valid      (s0_valid),
        .s0_vaddr      (s0_vaddr),
        .s0_asid       (s0_asid),
        .tlb_we        (tlb_we),
        .tlb_windex    (tlb_windex),
        .tlb_wvpn      (tlb_wvpn),
        .tlb_wasid     (tlb_wasid),
        .tlb_wg        (tlb_wg),
        .tlb_wpfn      (tlb_wpfn),
        .tlb_wc        (tlb_wc),
        .tlb_wv        (tlb_wv),
        .s1_valid      (s1_valid),
        .s1_vaddr      (s1_vaddr),
        .s1_found      (s1_found),
        .s1_pfn        (s1_pfn),
        .s1_c          (s1_c),
        .s1_v          (s1_v)
    );

    itlb_stage itlb_stage_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .s1_valid      (s1_valid),
        .s1_vaddr      (s1_vaddr),
        .s1_found      (s1_found),
        .s1_pfn        (s1_pfn),
        .s1_c          (s1_c),
        .s1_v          (s1_v),
        .resp_valid    (resp_valid),
        .resp_paddr    (resp_paddr),
        .resp_cattr    (resp_cattr),
        .resp_refill   (resp_refill),
        .resp_invalid  (resp_invalid)
    );

endmodule

//--- testbench/itlb_checker.sv
`timescale 1ns/1ps
// reference model of the translation path, samples the DUT ports on falling edges
// TLB writes are assumed to land only while nothing is in flight
// one result line per test, counts kept for the testbench top
module itlb_checker
    import itlb_pkg::*;
#(
    parameter int TLB_ENTRIES = 16,
    parameter int CREDITS     = 4
)
(
    input logic                           clk,
    input logic                           rst_n,
    input logic                           req_valid,
    input vaddr_t                         req_vaddr,
    input asid_t                          req_asid,
    input logic                           req_ready,
    input logic                           credit_return,
    input logic                           tlb_we,
    input logic [$clog2(TLB_ENTRIES)-1:0] tlb_windex,
    input vpn_t                           tlb_wvpn,
    input asid_t                          tlb_wasid,
    input logic                           tlb_wg,
    input pfn_t                           tlb_wpfn,
    input cattr_t                         tlb_wc,
    input logic                           tlb_wv,
    input logic                           resp_valid,
    input paddr_t                         resp_paddr,
    input cattr_t                         resp_cattr,
    input logic                           resp_refill,
    input logic                           resp_invalid
);

    // model entry {v, c, pfn, g, asid, vpn}
    logic [48:0] m_ent [TLB_ENTRIES];
    // expected responses in issue order {refill, invalid, cattr, paddr}
    logic [36:0] exp_q [$];
    // falling edge count at each acceptance, same order as exp_q
    int          issue_cyc [$];
    int          cyc          = 0;
    string       test_name    = "reset";
    int          test_errs    = 0;
    int          test_resps   = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    // accepted requests whose credit has not come back
    int          outstanding  = 0;

    // expected response, lowest matching entry wins
    function automatic logic [36:0] model_xlate(input vaddr_t va, input asid_t asid);
        logic [48:0] ent;
        logic        hit;
        logic [36:0] res;
        hit = 1'b0;
        // nothing matches, refill only
        res = {2'b10, 35'd0};
        for (int i = 0; i < TLB_ENTRIES; i++)
        begin
            ent = m_ent[i];
            if (!hit && ent[19:0] == va[31:12] && (ent[24] || ent[23:20] == asid))
            begin
                hit = 1'b1;
                res = ent[48] ? {2'b00, ent[47:45], ent[44:25], va[11:0]} : {2'b01, 35'd0};
            end
        end
        // unmapped windows ignore the TLB
        if (va[31:29] == 3'b100)
            res = {2'b00, 3'd3, va & 32'h7fff_ffff};
        else if (va[31:29] == 3'b101)
            res = {2'b00, 3'd2, va & 32'h1fff_ffff};
        return res;
    endfunction

    task automatic check_field(input string what, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        if (exp_v !== act_v)
        begin
            $display("ERR %s %s expected %h actual %h", test_name, what, exp_v, act_v);
            test_errs++;
        end
    endtask

    task automatic report_problem(input string msg);
        $display("test %s: %s", test_name, msg);
        test_errs++;
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_errs  = 0;
        test_resps = 0;
    endtask

    task automatic end_test();
        if (exp_q.size() != 0)
            report_problem($sformatf("%0d requests never got a response", exp_q.size()));
        exp_q.delete();
        issue_cyc.delete();
        if (test_errs == 0)
            tests_passed++;
        else
            tests_failed++;
        $display("test %s: %0d responses, %0d errors", test_name, test_resps, test_errs);
    endtask

    // falling edge, every port has settled
    always @(negedge clk)
    begin : sample
        logic [36:0] exp_r;
        int          t_issue;
        cyc++;
        if (!rst_n)
        begin
            for (int i = 0; i < TLB_ENTRIES; i++)
                m_ent[i] = '0;
            exp_q.delete();
            issue_cyc.delete();
            outstanding = 0;
        end
        else
        begin
            if (resp_valid && exp_q.size() == 0)
                report_problem("response arrived with no request in flight");
            else if (resp_valid)
            begin
                exp_r   = exp_q.pop_front();
                t_issue = issue_cyc.pop_front();
                test_resps++;
                check_field("paddr", exp_r[31:0], resp_paddr);
                check_field("cattr", exp_r[34:32], resp_cattr);
                check_field("invalid", exp_r[35], resp_invalid);
                check_field("refill", exp_r[36], resp_refill);
                // accepted at edge N, response seen after edge N+2
                check_field("latency", 3, cyc - t_issue);
            end
            if (tlb_we)
                m_ent[tlb_windex] = {tlb_wv, tlb_wc, tlb_wpfn, tlb_wg, tlb_wasid, tlb_wvpn};
            // lookup now, the entry array is stable while requests fly
            if (req_valid && req_ready)
            begin
                exp_q.push_back(model_xlate(req_vaddr, req_asid));
                issue_cyc.push_back(cyc);
                outstanding++;
            end
            if (credit_return)
                outstanding--;
            if (outstanding > CREDITS)
                report_problem("more requests outstanding than downstream credits");
        end
    end

endmodule

//--- testbench/tb_itlb_xlate.sv
`timescale 1ns/1ps
// testbench for the translation path, six seeded tests checked by itlb_checker
// downstream is a slot queue, each slot freed after a random delay
// inputs change 2 ns after the rising edge
module tb_itlb_xlate
    import itlb_pkg::*;
();

    localparam int TLB_ENTRIES = 16;
    localparam int CREDITS     = 4;
    localparam int IDX_W       = $clog2(TLB_ENTRIES);
    localparam int CLK_PERIOD  = 40;
    // request counts of the six tests
    localparam int TOTAL_REQS  = 40 + 40 + 40 + 20 + 12 + 300;
    localparam int CYCLE_LIMIT = 2 * TOTAL_REQS * (CREDITS + 3) + 4;

    logic             clk;
    logic             rst_n;
    logic             req_valid;
    vaddr_t           req_vaddr;
    asid_t            req_asid;
    logic             req_ready;
    logic             credit_return;
    logic             tlb_we;
    logic [IDX_W-1:0] tlb_windex;
    vpn_t             tlb_wvpn;
    asid_t            tlb_wasid;
    logic             tlb_wg;
    pfn_t             tlb_wpfn;
    cattr_t           tlb_wc;
    logic             tlb_wv;
    logic             resp_valid;
    paddr_t           resp_paddr;
    cattr_t           resp_cattr;
    logic             resp_refill;
    logic             resp_invalid;

    integer seed         = 32'h936b_c245;
    int     slot_q [$];
    logic   hold_credits = 1'b0;
    int     cycles       = 0;
    int     accepted;
    int     k;
    vaddr_t rnd;
    vaddr_t rnd2;
    // what was written, used to aim requests at entries
    vpn_t   ent_vpn  [TLB_ENTRIES];
    asid_t  ent_asid [TLB_ENTRIES];
    logic   ent_g    [TLB_ENTRIES];

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    itlb_xlate_top #(
        .TLB_ENTRIES (TLB_ENTRIES),
        .CREDITS     (CREDITS)
    ) itlb_xlate_top_inst (.*);

    itlb_checker #(
        .TLB_ENTRIES (TLB_ENTRIES),
        .CREDITS     (CREDITS)
    ) checker_inst (.*);

    // downstream slots, one credit back per cycle at most
    initial
    begin
        credit_return = 1'b0;
        forever
        begin
            @(negedge clk);
            if (resp_valid)
                slot_q.push_back(1 + ($random(seed) & 7));
            @(posedge clk);
            #2;
            credit_return = 1'b0;
            if (slot_q.size() > 0 && slot_q[0] > 0)
                slot_q[0] = slot_q[0] - 1;
            if (!hold_credits && slot_q.size() > 0 && slot_q[0] == 0)
            begin
                void'(slot_q.pop_front());
                credit_return = 1'b1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // held until accepted, returns 2 ns after the accepting edge
    task automatic send_req(input vaddr_t va, input asid_t asid);
        req_valid = 1'b1;
        req_vaddr = va;
        req_asid  = asid;
        do
            @(negedge clk);
        while (!req_ready);
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic write_entry(input int idx, input vpn_t vpn, input asid_t asid,
                               input logic g, input logic v);
        ent_vpn[idx]  = vpn;
        ent_asid[idx] = asid;
        ent_g[idx]    = g;
        tlb_we        = 1'b1;
        tlb_windex    = idx[IDX_W-1:0];
        tlb_wvpn      = vpn;
        tlb_wasid     = asid;
        tlb_wg        = g;
        tlb_wpfn      = $random(seed);
        tlb_wc        = $random(seed);
        tlb_wv        = v;
        @(posedge clk);
        #2;
        tlb_we = 1'b0;
    endtask

    // all responses back and all credits returned
    task automatic drain();
        while (checker_inst.outstanding != 0)
            @(posedge clk);
        @(posedge clk);
        #2;
    endtask

    initial
    begin
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_vaddr  = '0;
        req_asid   = '0;
        tlb_we     = 1'b0;
        tlb_windex = '0;
        tlb_wvpn   = '0;
        tlb_wasid  = '0;
        tlb_wg     = 1'b0;
        tlb_wpfn   = '0;
        tlb_wc     = '0;
        tlb_wv     = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        rst_n = 1'b1;

        // nibbles 8..B only, TLB filled with valid global entries on those pages
        checker_inst.start_test("unmapped");
        for (int i = 0; i < TLB_ENTRIES; i++)
        begin
            rnd = $random(seed);
            write_entry(i, {2'b10, rnd[17:0]}, rnd[21:18], 1'b1, 1'b1);
        end
        for (int n = 0; n < 40; n++)
        begin
            rnd = $random(seed);
            k   = rnd[31:16] % TLB_ENTRIES;
            if (rnd[0])
                send_req({2'b10, rnd[29:0]}, rnd[3:0]);
            else
                send_req({ent_vpn[k], rnd[11:0]}, rnd[7:4]);
        end
        drain();
        checker_inst.end_test();

        // distinct vpns in nibbles 0..7, every fourth entry global
        checker_inst.start_test("mapped hits");
        for (int i = 0; i < TLB_ENTRIES; i++)
        begin
            rnd = $random(seed);
            write_entry(i, {1'b0, rnd[14:0], i[3:0]}, rnd[19:16], (i % 4) == 3, 1'b1);
        end
        for (int n = 0; n < 40; n++)
        begin
            rnd = $random(seed);
            k   = rnd[31:16] % TLB_ENTRIES;
            send_req({ent_vpn[k], rnd[11:0]}, ent_g[k] ? rnd[7:4] : ent_asid[k]);
        end
        drain();
        checker_inst.end_test();

        // nibbles C..F are absent, or a private entry under a foreign asid
        checker_inst.start_test("refill");
        for (int n = 0; n < 40; n++)
        begin
            rnd = $random(seed);
            k   = 4 * (rnd[31:16] % (TLB_ENTRIES / 4));
            if (rnd[0])
                send_req({2'b11, rnd[29:0]}, rnd[7:4]);
            else
                send_req({ent_vpn[k], rnd[11:0]}, ent_asid[k] ^ (rnd[7:4] | 4'h1));
        end
        drain();
        checker_inst.end_test();

        // entries 0..3 rewritten with v low
        checker_inst.start_test("invalid");
        for (int i = 0; i < 4; i++)
            write_entry(i, ent_vpn[i], ent_asid[i], ent_g[i], 1'b0);
        for (int n = 0; n < 20; n++)
        begin
            rnd = $random(seed);
            k   = rnd[17:16];
            send_req({ent_vpn[k], rnd[11:0]}, ent_asid[k]);
        end
        drain();
        checker_inst.end_test();

        // no credits back for 20 cycles, request held high throughout
        checker_inst.start_test("credit back-pressure");
        hold_credits = 1'b1;
        accepted     = 0;
        req_valid    = 1'b1;
        repeat (20)
        begin
            rnd       = $random(seed);
            req_vaddr = rnd;
            req_asid  = rnd[3:0];
            @(negedge clk);
            if (req_ready)
                accepted++;
            @(posedge clk);
            #2;
        end
        req_valid = 1'b0;
        checker_inst.check_field("acceptances while credits held", CREDITS, accepted);
        checker_inst.check_field("req_ready while credits held", 0, req_ready);
        hold_credits = 1'b0;
        for (int n = accepted; n < 12; n++)
            send_req($random(seed), $random(seed));
        drain();
        checker_inst.end_test();

        // all segments, random gaps of up to 3 idle cycles
        checker_inst.start_test("random mix");
        for (int n = 0; n < 300; n++)
        begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            k    = rnd[31:16] % TLB_ENTRIES;
            #(CLK_PERIOD * (rnd[2] ? rnd[1:0] : 0));
            if (rnd[3])
                send_req(rnd2, rnd[7:4]);
            else
                send_req({ent_vpn[k], rnd2[11:0]}, rnd[4] ? rnd[7:4] : ent_asid[k]);
        end
        drain();
        checker_inst.end_test();

        $display("tests passed %0d, failed %0d", checker_inst.tests_passed,
                 checker_inst.tests_failed);
        if (checker_inst.tests_failed == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- itlb_xlate_top.f
design/itlb_pkg.sv
design/fetch_issue.sv
design/tlb_lookup.sv
design/itlb_stage.sv
design/itlb_xlate_top.sv
testbench/itlb_checker.sv
testbench/tb_itlb_xlate.sv
